/* verilog/mem_pkg.sv */
/*
 * Shared types and constants for the memory stage and its L1.5 port.
 * Opcode bit 3 selects store, bits 2:1 the access width, bit 0 signed loads.
 * QUEUE_DEPTH must stay at 2 or more so the pointer width is non-zero.
 */
`default_nettype none

package mem_pkg;

    // plain vector types
    typedef logic [3:0]  mem_op_t;
    typedef logic [31:0] word_t;
    typedef logic [63:0] line_half_t;     // one half of a 16 byte cache line
    typedef logic [3:0]  byte_en_t;       // bit 0 is byte address 0
    typedef logic [3:0]  rqtype_t;
    typedef logic [3:0]  rettype_t;
    typedef logic [2:0]  msg_size_t;

    // memory opcodes
    //   stores: SW 1111, SH 1011, SB 1101
    //   loads:  LW 0111, LH 0011, LHU 0010, LB 0101, LBU 0100
    localparam mem_op_t OP_NONE = 4'b0000;
    localparam mem_op_t OP_SW   = 4'b1111;
    localparam mem_op_t OP_SH   = 4'b1011;
    localparam mem_op_t OP_SB   = 4'b1101;
    localparam mem_op_t OP_LW   = 4'b0111;
    localparam mem_op_t OP_LH   = 4'b0011;
    localparam mem_op_t OP_LHU  = 4'b0010;
    localparam mem_op_t OP_LB   = 4'b0101;
    localparam mem_op_t OP_LBU  = 4'b0100;

    // width field, opcode bits 2:1
    localparam logic [1:0] WIDTH_WORD = 2'b11;
    localparam logic [1:0] WIDTH_HALF = 2'b01;
    localparam logic [1:0] WIDTH_BYTE = 2'b10;

    // L1.5 request types
    localparam rqtype_t LOAD_RQ  = 4'b0000;
    localparam rqtype_t STORE_RQ = 4'b0001;

    // L1.5 return types
    localparam rettype_t LOAD_RET = 4'b0000;
    localparam rettype_t ST_ACK   = 4'b0100;

    // message size codes
    localparam msg_size_t MSG_SIZE_1B = 3'b001;
    localparam msg_size_t MSG_SIZE_2B = 3'b010;
    localparam msg_size_t MSG_SIZE_4B = 3'b011;

    // request queue, also the decoder's starting credit count
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [QUEUE_PTR_W-1:0] qptr_t;
    typedef logic [QUEUE_PTR_W:0]   qcount_t;   // holds 0..QUEUE_DEPTH

endpackage

`default_nettype wire

/* verilog/mem_decode.sv */
/*
 * Two register stages of address generation and lane decode.
 * An opcode of zero is consumed without a credit and never reaches the queue.
 * Misaligned accesses get all byte lanes cleared.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_decode (
    input  logic              clk,
    input  logic              nrst,
    input  logic              op_valid,
    input  mem_pkg::mem_op_t  mem_op,
    input  mem_pkg::word_t    op_a,
    input  mem_pkg::word_t    op_b,
    input  mem_pkg::word_t    s_imm,
    input  logic              credit_return,
    output logic              op_ready,
    output logic              push,
    output mem_pkg::word_t    addr,
    output mem_pkg::word_t    wdata,
    output mem_pkg::byte_en_t byte_en,
    output mem_pkg::mem_op_t  dec_op,
    output logic              misaligned
);
    import mem_pkg::*;

    qcount_t  credits;
    logic     accept;
    logic     s1_valid;
    mem_op_t  s1_op;
    word_t    s1_a;
    word_t    s1_b;
    word_t    s1_imm;
    word_t    ea;
    logic     ea_mis;
    byte_en_t lanes;

    assign op_ready = (credits != '0);
    assign accept   = op_valid && op_ready && (mem_op != OP_NONE);

    // one credit per free queue slot, taken at acceptance
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            credits <= qcount_t'(QUEUE_DEPTH);
        end else begin
            credits <= credits - qcount_t'(accept) + qcount_t'(credit_return);
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            s1_valid <= 1'b0;
            push     <= 1'b0;
        end else begin
            s1_valid <= accept;
            push     <= s1_valid;
        end
    end

    // stage one operands
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_op  <= mem_op;
            s1_a   <= op_a;
            s1_b   <= op_b;
            s1_imm <= s_imm;
        end
    end

    assign ea = s1_op[3] ? (s1_a + s1_imm) : (s1_a + s1_b);   // store offset vs I imm

    // half needs bit 0 clear, word needs bits 1:0 clear
    assign ea_mis = (s1_op[1] & ea[0]) | (s1_op[2] & s1_op[1] & ea[1]);

    always_comb begin
        case (s1_op[2:1])
            WIDTH_WORD: lanes = 4'b1111;
            WIDTH_HALF: lanes = ea[1] ? 4'b1100 : 4'b0011;
            WIDTH_BYTE: lanes = 4'b0001 << ea[1:0];
            default:    lanes = 4'b0000;
        endcase
        if (ea_mis) begin
            lanes = 4'b0000;
        end
    end

    // stage two results
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            addr       <= ea;
            wdata      <= s1_b;
            byte_en    <= lanes;
            dec_op     <= s1_op;
            misaligned <= ea_mis;
        end
    end

    // credits come back from the queue, never more than were handed out
    a_credit_bound: assert property (@(posedge clk) disable iff (!nrst)
        credits <= qcount_t'(QUEUE_DEPTH));

endmodule

`default_nettype wire

/* verilog/req_queue.sv */
/*
 * Circular buffer of decoded requests, head shown combinationally.
 * A credit is returned in the same cycle as each pop.
 */
`timescale 1ns/1ps
`default_nettype none

module req_queue (
    input  logic              clk,
    input  logic              nrst,
    input  logic              push,
    input  mem_pkg::word_t    addr,
    input  mem_pkg::word_t    wdata,
    input  mem_pkg::byte_en_t byte_en,
    input  mem_pkg::mem_op_t  dec_op,
    input  logic              misaligned,
    input  logic              take,
    output logic              head_valid,
    output mem_pkg::word_t    head_addr,
    output mem_pkg::word_t    head_wdata,
    output mem_pkg::byte_en_t head_byte_en,
    output mem_pkg::mem_op_t  head_op,
    output logic              head_misaligned,
    output logic              credit_return
);
    import mem_pkg::*;

    word_t    addr_mem  [QUEUE_DEPTH];
    word_t    wdata_mem [QUEUE_DEPTH];
    byte_en_t be_mem    [QUEUE_DEPTH];
    mem_op_t  op_mem    [QUEUE_DEPTH];
    logic     mis_mem   [QUEUE_DEPTH];
    qptr_t    wr_ptr;
    qptr_t    rd_ptr;
    qcount_t  count;
    logic     pop;

    function automatic qptr_t ptr_next(input qptr_t p);
        return (p == qptr_t'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_valid    = (count != '0);
    assign pop           = take && head_valid;
    assign credit_return = pop;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (pop)  rd_ptr <= ptr_next(rd_ptr);
            count <= count + qcount_t'(push) - qcount_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr]  <= addr;
            wdata_mem[wr_ptr] <= wdata;
            be_mem[wr_ptr]    <= byte_en;
            op_mem[wr_ptr]    <= dec_op;
            mis_mem[wr_ptr]   <= misaligned;
        end
    end

    assign head_addr       = addr_mem[rd_ptr];
    assign head_wdata      = wdata_mem[rd_ptr];
    assign head_byte_en    = be_mem[rd_ptr];
    assign head_op         = op_mem[rd_ptr];
    assign head_misaligned = mis_mem[rd_ptr];

    // decoder credits must keep the queue from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (!nrst)
        push |-> (count != qcount_t'(QUEUE_DEPTH)));

    // port only takes an entry it can see
    a_no_underflow: assert property (@(posedge clk) disable iff (!nrst)
        take |-> head_valid);

endmodule

`default_nettype wire

/* verilog/l15_port.sv */
/*
 * One outstanding L1.5 transaction at a time; misaligned heads skip the cache.
 * Store data is the register value byte-reversed, not shifted into its lane.
 * load_data and the exception flags are meaningful only while done is high.
 */
`timescale 1ns/1ps
`default_nettype none

module l15_port (
    input  logic                clk,
    input  logic                nrst,
    input  logic                head_valid,
    input  mem_pkg::word_t      head_addr,
    input  mem_pkg::word_t      head_wdata,
    input  mem_pkg::byte_en_t   head_byte_en,
    input  mem_pkg::mem_op_t    head_op,
    input  logic                head_misaligned,
    input  logic                l15_header_ack,
    input  logic                l15_resp_val,
    input  mem_pkg::rettype_t   l15_returntype,
    input  mem_pkg::line_half_t l15_data_0,
    input  mem_pkg::line_half_t l15_data_1,
    output logic                take,
    output mem_pkg::rqtype_t    l15_rqtype,
    output mem_pkg::msg_size_t  l15_size,
    output mem_pkg::word_t      l15_address,
    output mem_pkg::word_t      l15_data,
    output logic                l15_val,
    output logic                l15_req_ack,
    output logic                done,
    output mem_pkg::word_t      load_data,
    output logic                ld_misaligned,
    output logic                st_misaligned
);
    import mem_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT, ST_RESP} port_state_t;

    port_state_t state;
    mem_op_t     cur_op;
    logic        cur_mis;
    logic        resp_match;
    msg_size_t   st_size;
    word_t       line_word;
    word_t       swapped;
    word_t       shifted;
    word_t       ld_value;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (head_valid) state <= head_misaligned ? ST_RESP : ST_REQ;
                ST_REQ:  if (l15_header_ack) state <= ST_WAIT;
                ST_WAIT: if (l15_req_ack) state <= ST_RESP;
                default: state <= ST_IDLE;   // respond lasts one cycle
            endcase
        end
    end

    // size from the number of store lanes
    always_comb begin
        case (head_byte_en)
            4'b1111:          st_size = MSG_SIZE_4B;
            4'b0011, 4'b1100: st_size = MSG_SIZE_2B;
            default:          st_size = MSG_SIZE_1B;
        endcase
    end

    // latch the head when it is first seen
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && head_valid) begin
            cur_op      <= head_op;
            cur_mis     <= head_misaligned;
            l15_address <= head_addr;
            l15_data    <= {head_wdata[7:0], head_wdata[15:8],
                            head_wdata[23:16], head_wdata[31:24]};   // big-endian cache
            l15_rqtype  <= head_op[3] ? STORE_RQ : LOAD_RQ;
            l15_size    <= head_op[3] ? st_size : MSG_SIZE_4B;
        end
        if (l15_req_ack) begin
            load_data <= ld_value;
        end
    end

    assign resp_match  = (l15_rqtype == STORE_RQ) ? (l15_returntype == ST_ACK)
                                                  : (l15_returntype == LOAD_RET);
    assign l15_req_ack = (state == ST_WAIT) && l15_resp_val && resp_match;

    // word within the 16 byte line
    always_comb begin
        case (l15_address[3:2])
            2'b00:   line_word = l15_data_0[63:32];
            2'b01:   line_word = l15_data_0[31:0];
            2'b10:   line_word = l15_data_1[63:32];
            default: line_word = l15_data_1[31:0];
        endcase
    end

    assign swapped = {line_word[7:0], line_word[15:8], line_word[23:16], line_word[31:24]};
    assign shifted = swapped >> {l15_address[1:0], 3'b000};   // requested byte to lane 0

    always_comb begin
        case (cur_op[2:0])
            3'b111:  ld_value = swapped;                               // lw
            3'b011:  ld_value = {{16{shifted[15]}}, shifted[15:0]};    // lh
            3'b010:  ld_value = {16'b0, shifted[15:0]};                // lhu
            3'b101:  ld_value = {{24{shifted[7]}}, shifted[7:0]};      // lb
            3'b100:  ld_value = {24'b0, shifted[7:0]};                 // lbu
            default: ld_value = '0;
        endcase
        if (cur_op[3]) begin
            ld_value = '0;   // stores return nothing
        end
    end

    assign l15_val       = (state == ST_REQ);
    assign take          = (state == ST_RESP);
    assign done          = (state == ST_RESP);
    assign ld_misaligned = done && cur_mis && !cur_op[3];
    assign st_misaligned = done && cur_mis && cur_op[3];

    // the cache only acknowledges a header that is on offer
    a_ack_with_val: assert property (@(posedge clk) disable iff (!nrst)
        l15_header_ack |-> l15_val);

endmodule

`default_nettype wire

/* verilog/mem_wrap.sv */
/*
 * Memory stage top: decode, request queue and L1.5 port.
 * op_ready follows the decoder credits, so hold op_valid until it is seen high.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_wrap (
    input  logic                clk,
    input  logic                nrst,
    // pipeline side
    input  logic                op_valid,
    output logic                op_ready,
    input  mem_pkg::mem_op_t    mem_op,
    input  mem_pkg::word_t      op_a,
    input  mem_pkg::word_t      op_b,
    input  mem_pkg::word_t      s_imm,
    output logic                done,
    output mem_pkg::word_t      load_data,
    output logic                ld_misaligned,
    output logic                st_misaligned,
    // L1.5 request
    output mem_pkg::rqtype_t    l15_rqtype,
    output mem_pkg::msg_size_t  l15_size,
    output mem_pkg::word_t      l15_address,
    output mem_pkg::word_t      l15_data,
    output logic                l15_val,
    input  logic                l15_header_ack,
    // L1.5 response
    input  logic                l15_resp_val,
    input  mem_pkg::rettype_t   l15_returntype,
    input  mem_pkg::line_half_t l15_data_0,
    input  mem_pkg::line_half_t l15_data_1,
    output logic                l15_req_ack
);
    import mem_pkg::*;

    logic     dec_push;
    word_t    dec_addr;
    word_t    dec_wdata;
    byte_en_t dec_byte_en;
    mem_op_t  dec_op;
    logic     dec_misaligned;
    logic     credit_return;
    logic     head_valid;
    word_t    head_addr;
    word_t    head_wdata;
    byte_en_t head_byte_en;
    mem_op_t  head_op;
    logic     head_misaligned;
    logic     take;

    mem_decode i_decode (
        .clk           (clk),
        .nrst          (nrst),
        .op_valid      (op_valid),
        .mem_op        (mem_op),
        .op_a          (op_a),
        .op_b          (op_b),
        .s_imm         (s_imm),
        .credit_return (credit_return),
        .op_ready      (op_ready),
        .push          (dec_push),
        .addr          (dec_addr),
        .wdata         (dec_wdata),
        .byte_en       (dec_byte_en),
        .dec_op        (dec_op),
        .misaligned    (dec_misaligned)
    );

    req_queue i_queue (
        .clk             (clk),
        .nrst            (nrst),
        .push            (dec_push),
        .addr            (dec_addr),
        .wdata           (dec_wdata),
        .byte_en         (dec_byte_en),
        .dec_op          (dec_op),
        .misaligned      (dec_misaligned),
        .take            (take),
        .head_valid      (head_valid),
        .head_addr       (head_addr),
        .head_wdata      (head_wdata),
        .head_byte_en    (head_byte_en),
        .head_op         (head_op),
        .head_misaligned (head_misaligned),
        .credit_return   (credit_return)
    );

    l15_port i_port (
        .clk             (clk),
        .nrst            (nrst),
        .head_valid      (head_valid),
        .head_addr       (head_addr),
        .head_wdata      (head_wdata),
        .head_byte_en    (head_byte_en),
        .head_op         (head_op),
        .head_misaligned (head_misaligned),
        .l15_header_ack  (l15_header_ack),
        .l15_resp_val    (l15_resp_val),
        .l15_returntype  (l15_returntype),
        .l15_data_0      (l15_data_0),
        .l15_data_1      (l15_data_1),
        .take            (take),
        .l15_rqtype      (l15_rqtype),
        .l15_size        (l15_size),
        .l15_address     (l15_address),
        .l15_data        (l15_data),
        .l15_val         (l15_val),
        .l15_req_ack     (l15_req_ack),
        .done            (done),
        .load_data       (load_data),
        .ld_misaligned   (ld_misaligned),
        .st_misaligned   (st_misaligned)
    );

endmodule

`default_nettype wire

/* test/l15_model.sv */
/*
 * Behavioral L1.5 cache with a word memory of 2**ADDR_BITS bytes, addresses wrap.
 * Serves one transaction at a time with random delays of 0 to max_delay cycles.
 * stall holds back the header ack; store bytes sit in the top of l15_data.
 */
`timescale 1ns/1ps
`default_nettype none

module l15_model #(
    parameter int ADDR_BITS = 10,
    parameter int SEED      = 39245
) (
    input  logic                clk,
    input  logic                nrst,
    input  logic                stall,
    input  int                  max_delay,
    input  mem_pkg::rqtype_t    l15_rqtype,
    input  mem_pkg::msg_size_t  l15_size,
    input  mem_pkg::word_t      l15_address,
    input  mem_pkg::word_t      l15_data,
    input  logic                l15_val,
    input  logic                l15_req_ack,
    output logic                l15_header_ack,
    output logic                l15_resp_val,
    output mem_pkg::rettype_t   l15_returntype,
    output mem_pkg::line_half_t l15_data_0,
    output mem_pkg::line_half_t l15_data_1,
    output int                  req_count
);
    import mem_pkg::*;

    localparam int WORDS = 2 ** (ADDR_BITS - 2);

    word_t     mem [WORDS];   // little-endian words
    integer    seed;
    rqtype_t   rq;
    msg_size_t sz;
    word_t     a;
    word_t     d;
    word_t     ba;
    int        nbytes;
    int        n;
    int        wi;
    int        i;
    int        k;

    function automatic word_t swap_bytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    task automatic wait_cycles(input int c);
        repeat (c) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        seed           = SEED;
        l15_header_ack = 1'b0;
        l15_resp_val   = 1'b0;
        l15_returntype = LOAD_RET;
        l15_data_0     = '0;
        l15_data_1     = '0;
        req_count      = 0;
        for (i = 0; i < WORDS; i++) begin
            mem[i] = word_t'(i) * 32'h9e37_79b9 + 32'h1357_2468;
        end
        forever begin
            @(posedge clk);
            #1;
            if (nrst && l15_val) begin
                rq = l15_rqtype;
                sz = l15_size;
                a  = l15_address;
                d  = l15_data;
                req_count++;
                while (stall) begin
                    wait_cycles(1);
                end
                wait_cycles($unsigned($random(seed)) % (max_delay + 1));
                l15_header_ack = 1'b1;
                wait_cycles(1);
                l15_header_ack = 1'b0;

                if (rq == STORE_RQ) begin
                    nbytes = (sz == MSG_SIZE_4B) ? 4 : (sz == MSG_SIZE_2B) ? 2 : 1;
                    for (k = 0; k < nbytes; k++) begin
                        ba = a + word_t'(k);
                        mem[ba[ADDR_BITS-1:2]][8*ba[1:0] +: 8] = d[31-8*k -: 8];  // big-endian
                    end
                    l15_returntype = ST_ACK;
                end else begin
                    l15_returntype = LOAD_RET;
                end
                // whole 16 byte line, big-endian words
                wi = int'({a[ADDR_BITS-1:4], 2'b00});
                l15_data_0 = {swap_bytes(mem[wi]), swap_bytes(mem[wi+1])};
                l15_data_1 = {swap_bytes(mem[wi+2]), swap_bytes(mem[wi+3])};

                wait_cycles($unsigned($random(seed)) % (max_delay + 1));
                l15_resp_val = 1'b1;
                n = 0;
                do begin
                    @(negedge clk);
                    n++;
                end while (!l15_req_ack && n < 1000);
                @(posedge clk);
                #1;
                l15_resp_val = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_mem_wrap.sv */
/*
 * Testbench for mem_wrap with a behavioral L1.5 model behind it.
 * Expected results are computed at acceptance and checked in order on each done.
 * Addresses wrap at 2**ADDR_BITS bytes, the size of the model memory.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_wrap;
    import mem_pkg::*;

    localparam int ADDR_BITS = 10;
    localparam int TIMEOUT   = 2000;   // cycles per wait
    localparam int N_RANDOM  = 300;

    typedef struct packed {
        logic  check_data;
        logic  is_store;
        logic  ld_mis;
        logic  st_mis;
        word_t data;
        word_t addr;
        word_t mem_word;   // word at addr once this op is done
    } exp_t;

    logic       clk;
    logic       nrst;
    logic       op_valid;
    logic       op_ready;
    mem_op_t    mem_op;
    word_t      op_a;
    word_t      op_b;
    word_t      s_imm;
    logic       done;
    word_t      load_data;
    logic       ld_misaligned;
    logic       st_misaligned;
    rqtype_t    l15_rqtype;
    msg_size_t  l15_size;
    word_t      l15_address;
    word_t      l15_data;
    logic       l15_val;
    logic       l15_header_ack;
    logic       l15_resp_val;
    rettype_t   l15_returntype;
    line_half_t l15_data_0;
    line_half_t l15_data_1;
    logic       l15_req_ack;
    logic       stall;
    int         max_delay;
    int         req_count;
    int         last_req_count;
    integer     seed;
    logic [7:0] shadow [2**ADDR_BITS];
    exp_t       exp_q [$];
    mem_op_t    op_list [8] = '{OP_SW, OP_SH, OP_SB, OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};

    mem_wrap i_dut (.*);

    l15_model #(.ADDR_BITS(ADDR_BITS), .SEED(39245)) i_model (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // expected outcome of one operation, stores update the shadow memory
    function automatic exp_t ref_op(input mem_op_t op, input word_t a, input word_t b,
                                    input word_t imm);
        exp_t  e;
        word_t ea;
        word_t ba;
        word_t v;
        word_t wa;
        logic  mis;
        int    nb;
        int    k;
        ea  = op[3] ? a + imm : a + b;
        nb  = (op[2:1] == WIDTH_WORD) ? 4 : (op[2:1] == WIDTH_HALF) ? 2 : 1;
        mis = (nb == 2 && ea[0]) || (nb == 4 && ea[1:0] != 2'b00);
        v   = '0;
        for (k = 0; k < nb; k++) begin
            ba = ea + word_t'(k);
            if (op[3] && !mis) begin
                shadow[ba[ADDR_BITS-1:0]] = b[8*k +: 8];
            end
            v[8*k +: 8] = shadow[ba[ADDR_BITS-1:0]];
        end
        if (!op[3] && op[0] && nb == 1) v = {{24{v[7]}}, v[7:0]};
        if (!op[3] && op[0] && nb == 2) v = {{16{v[15]}}, v[15:0]};
        wa = {ea[31:2], 2'b00};
        e.mem_word   = {shadow[ADDR_BITS'(wa + 3)], shadow[ADDR_BITS'(wa + 2)],
                        shadow[ADDR_BITS'(wa + 1)], shadow[ADDR_BITS'(wa)]};
        e.check_data = !op[3] && !mis;
        e.is_store   = op[3];
        e.ld_mis     = mis && !op[3];
        e.st_mis     = mis && op[3];
        e.data       = v;
        e.addr       = ea;
        return e;
    endfunction

    // called just after a rising edge, returns just after the accepting edge
    task automatic issue_op(input mem_op_t op, input word_t a, input word_t b, input word_t imm);
        int n;
        op_valid = 1'b1;
        mem_op   = op;
        op_a     = a;
        op_b     = b;
        s_imm    = imm;
        n = 0;
        while (!op_ready) begin
            assert (n < TIMEOUT) else fail_run("timed out waiting for op_ready");
            @(posedge clk);
            #1;
            n++;
        end
        @(posedge clk);
        exp_q.push_back(ref_op(op, a, b, imm));
        #1;
        op_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int c);
        repeat (c) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            assert (n < TIMEOUT) else fail_run("timed out waiting for outstanding results");
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    always @(negedge clk) begin : compare_results
        exp_t e;
        if (nrst && done) begin
            assert (exp_q.size() > 0) else fail_run("done pulsed with no operation pending");
            e = exp_q.pop_front();
            assert (ld_misaligned == e.ld_mis) else fail_run($sformatf(
                "error ld_misaligned: got 0x%0h expected 0x%0h", ld_misaligned, e.ld_mis));
            assert (st_misaligned == e.st_mis) else fail_run($sformatf(
                "error st_misaligned: got 0x%0h expected 0x%0h", st_misaligned, e.st_mis));
            if (e.check_data) begin
                assert (load_data == e.data) else fail_run($sformatf(
                    "error load_data: got 0x%08h expected 0x%08h", load_data, e.data));
            end
            if (e.is_store) begin
                assert (i_model.mem[e.addr[ADDR_BITS-1:2]] == e.mem_word) else fail_run(
                    $sformatf("error mem[0x%03h]: got 0x%08h expected 0x%08h",
                              e.addr[ADDR_BITS-1:0], i_model.mem[e.addr[ADDR_BITS-1:2]],
                              e.mem_word));
            end
            if (e.ld_mis || e.st_mis) begin
                assert (req_count == last_req_count)
                    else fail_run("a misaligned access made a cache request");
            end else begin
                assert (req_count == last_req_count + 1)
                    else fail_run("an aligned access did not make exactly one cache request");
            end
            last_req_count = req_count;
        end
    end

    initial begin : main
        int      i;
        mem_op_t op;
        word_t   base;
        word_t   off;
        word_t   data;
        word_t   junk;
        seed           = 39245;
        nrst           = 1'b0;
        op_valid       = 1'b0;
        mem_op         = OP_NONE;
        op_a           = '0;
        op_b           = '0;
        s_imm          = '0;
        stall          = 1'b0;
        max_delay      = 0;
        last_req_count = 0;
        repeat (3) @(posedge clk);
        #1;
        nrst = 1'b1;
        assert (op_ready && !i_dut.dec_push && !i_dut.take && !l15_val && !l15_req_ack && !done)
            else fail_run("outputs not in their idle state after reset");
        for (i = 0; i < 2**ADDR_BITS; i++) begin
            shadow[i] = i_model.mem[i / 4][8*(i % 4) +: 8];
        end

        // stores then loads of every width, offsets from s_imm and op_b
        issue_op(OP_SW,  32'h0f0, 32'h8a7b_f6e5, 32'h010);   // 0x100
        issue_op(OP_LW,  32'h080, 32'h080, 32'h05c);
        issue_op(OP_LH,  32'h100, 32'h002, 32'h077);
        issue_op(OP_LHU, 32'h100, 32'h002, 32'h0);
        issue_op(OP_LB,  32'h100, 32'h001, 32'h0);
        issue_op(OP_LBU, 32'h100, 32'h003, 32'h0);
        issue_op(OP_SH,  32'h100, 32'h1234_c3a5, 32'h006);
        issue_op(OP_LH,  32'h104, 32'h002, 32'h0);
        issue_op(OP_SB,  32'h108, 32'hdead_be80, 32'h001);
        issue_op(OP_LB,  32'h108, 32'h001, 32'h0);
        issue_op(OP_LBU, 32'h108, 32'h001, 32'h0);
        issue_op(OP_LW,  32'h108, 32'h0, 32'h0);
        drain();

        // misaligned, no memory change and no cache traffic
        issue_op(OP_SW,  32'h100, 32'h1111_1111, 32'h002);
        issue_op(OP_SH,  32'h100, 32'h2222_2222, 32'h001);
        issue_op(OP_LW,  32'h100, 32'h003, 32'h0);
        issue_op(OP_LH,  32'h100, 32'h005, 32'h0);
        issue_op(OP_LHU, 32'h100, 32'h007, 32'h0);
        issue_op(OP_LW,  32'h100, 32'h0, 32'h0);
        drain();

        // header ack held back until credits run out
        stall = 1'b1;
        for (i = 0; i < QUEUE_DEPTH; i++) begin
            issue_op(OP_LW, 32'h200, word_t'(4 * i), 32'h0);
        end
        assert (!op_ready) else fail_run("op_ready still high with all queue entries in use");
        for (i = 0; i < 8; i++) begin
            idle_cycles(1);
            assert (!op_ready) else fail_run("op_ready rose while the cache was stalled");
        end
        assert (l15_val) else fail_run("no cache request pending during the stall");
        assert (exp_q.size() == QUEUE_DEPTH) else fail_run("results arrived during the stall");
        stall = 1'b0;
        drain();

        // random mix with random cache delays
        max_delay = 3;
        for (i = 0; i < N_RANDOM; i++) begin
            op   = op_list[$unsigned($random(seed)) % 8];
            base = $unsigned($random(seed)) & 32'h0fc;
            off  = $unsigned($random(seed)) & 32'h03f;
            if ($unsigned($random(seed)) % 6 != 0) begin
                if (op[2:1] == WIDTH_WORD) off = off & ~32'h3;
                if (op[2:1] == WIDTH_HALF) off = off & ~32'h1;
            end
            data = $random(seed);
            junk = $random(seed);
            if (op[3]) begin
                issue_op(op, base, data, off);
            end else begin
                issue_op(op, base, off, junk);
            end
            if ($unsigned($random(seed)) % 4 == 0) begin
                idle_cycles($unsigned($random(seed)) % 3 + 1);
            end
        end
        drain();

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* mem_wrap.f */
verilog/mem_pkg.sv
verilog/mem_decode.sv
verilog/req_queue.sv
verilog/l15_port.sv
verilog/mem_wrap.sv
test/l15_model.sv
test/tb_mem_wrap.sv

/* Makefile */
# Verilator build and run of the memory stage testbench

VERILATOR  ?= verilator
TOP        ?= tb_mem_wrap
RTL_TOP    ?= mem_wrap
FILELIST   ?= mem_wrap.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= -Wno-fatal -j 0
LINT_FLAGS ?= -Wall
RTL_SRCS   ?= verilog/mem_pkg.sv verilog/mem_decode.sv verilog/req_queue.sv \
              verilog/l15_port.sv verilog/mem_wrap.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
